// ==== logic/sys1_cart_pkg.sv ====
// ################################################
// shared types and constants for the cartridge side
// region bases are byte addresses of the download stream
// game type codes follow the protection chip numbering
// ################################################

package sys1_cart_pkg;

	// ################################################
	// data and address widths
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] prog_word_t;
	typedef logic [24:0] dl_addr_t;
	// MADEC bits 15 to 1
	typedef logic [14:0] prog_addr_t;
	typedef logic [13:0] snd_addr_t;
	// active low selects
	typedef logic [4:0]  rom_sel_t;
	typedef logic [2:0]  snd_sel_t;
	// SW5 down to SW1, active low
	typedef logic [4:0]  sw_bits_t;
	typedef logic [7:0]  adc_t;
	// up, down, left, right
	typedef logic [3:0]  udlr_t;

	// ################################################
	// write target of a download byte
	typedef enum logic [3:0]
	{
		rgn_none, rgn_rom0, rgn_rom1, rgn_rom2, rgn_rom5, rgn_rom6, rgn_rom7,
		rgn_slap, rgn_srom0, rgn_srom1, rgn_srom2
	} rom_region_e;

	// protection chip type
	typedef enum logic [7:0]
	{
		gt_marble   = 8'd103,
		gt_indytemp = 8'd105,
		gt_peterpak = 8'd107,
		gt_roadrunn = 8'd108,
		gt_roadb109 = 8'd109,
		gt_roadb110 = 8'd110
	} game_type_e;

	localparam game_type_e game_type_reset = gt_indytemp;

	// stream indices
	localparam byte_t dl_index_rom  = 8'd0;
	localparam byte_t dl_index_type = 8'd1;

	// bank depths in words or bytes
	localparam int depth_short_words = 16384;
	localparam int depth_long_words  = 32768;
	localparam int depth_sound       = 16384;

	// ################################################
	// region bases, matched on the upper bits only
	localparam dl_addr_t base_rom0  = 25'h400000;
	localparam dl_addr_t base_rom1  = 25'h410000;
	localparam dl_addr_t base_rom2  = 25'h420000;
	localparam dl_addr_t base_rom5  = 25'h450000;
	localparam dl_addr_t base_rom6  = 25'h460000;
	localparam dl_addr_t base_rom7  = 25'h470000;
	localparam dl_addr_t base_slap  = 25'h480000;
	localparam dl_addr_t base_srom0 = 25'h488000;
	localparam dl_addr_t base_srom1 = 25'h48C000;
	localparam dl_addr_t base_srom2 = 25'h490000;

endpackage

// ==== logic/cart_loader.sv ====
// ################################################
// download stream decoder, no back-pressure
// word regions expect the even byte before the odd one
// only the odd byte of a word region causes a write
// ################################################

module cart_loader
(
	input  logic                       clk_sys,
	input  logic                       rst_n,
	input  logic                       dl_download,
	input  logic                       dl_wr,
	input  sys1_cart_pkg::byte_t       dl_index,
	input  sys1_cart_pkg::dl_addr_t    dl_addr,
	input  sys1_cart_pkg::byte_t       dl_data,
	output logic                       wr_en,
	output sys1_cart_pkg::rom_region_e wr_region,
	output sys1_cart_pkg::prog_addr_t  wr_word_addr,
	output sys1_cart_pkg::snd_addr_t   wr_snd_addr,
	output sys1_cart_pkg::prog_word_t  wr_word,
	output sys1_cart_pkg::byte_t       wr_byte,
	output sys1_cart_pkg::game_type_e  game_type
);

	import sys1_cart_pkg::*;

	logic        rom_byte;
	logic        type_byte;
	logic        is_sound;
	logic        do_write;
	rom_region_e region;
	// even byte waiting for its odd partner
	byte_t       hi_byte;

	// stream qualification
	assign rom_byte  = dl_wr && dl_download && (dl_index == dl_index_rom);
	assign type_byte = dl_wr && (dl_index == dl_index_type);

	// ################################################
	// region decode from the upper address bits
	always_comb
	begin
		region = rgn_none;
		// 32K byte regions
		if (dl_addr[24:15] == base_rom0[24:15])
			region = rgn_rom0;
		else if (dl_addr[24:15] == base_slap[24:15])
			region = rgn_slap;
		// 64K byte regions
		else if (dl_addr[24:16] == base_rom1[24:16])
			region = rgn_rom1;
		else if (dl_addr[24:16] == base_rom2[24:16])
			region = rgn_rom2;
		else if (dl_addr[24:16] == base_rom5[24:16])
			region = rgn_rom5;
		else if (dl_addr[24:16] == base_rom6[24:16])
			region = rgn_rom6;
		else if (dl_addr[24:16] == base_rom7[24:16])
			region = rgn_rom7;
		// 16K sound regions
		else if (dl_addr[24:14] == base_srom0[24:14])
			region = rgn_srom0;
		else if (dl_addr[24:14] == base_srom1[24:14])
			region = rgn_srom1;
		else if (dl_addr[24:14] == base_srom2[24:14])
			region = rgn_srom2;
	end

	assign is_sound = (region == rgn_srom0) || (region == rgn_srom1) || (region == rgn_srom2);
	// sound writes every byte, words only on the odd byte
	assign do_write = rom_byte && (region != rgn_none) && (is_sound || dl_addr[0]);

	// high half of the word
	always_ff @(posedge clk_sys)
	begin
		if (rom_byte && !dl_addr[0])
			hi_byte <= dl_data;
	end

	// write payload
	always_ff @(posedge clk_sys)
	begin
		wr_word_addr <= dl_addr[15:1];
		wr_snd_addr  <= dl_addr[13:0];
		wr_word      <= {hi_byte, dl_data};
		wr_byte      <= dl_data;
	end

	// ################################################
	// write strobe, region and game type
	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_en     <= 1'b0;
			wr_region <= rgn_none;
			game_type <= game_type_reset;
		end
		else
		begin
			wr_en     <= do_write;
			wr_region <= do_write ? region : rgn_none;
			// raw code kept, unknown codes fall to the default map
			if (type_byte)
				game_type <= game_type_e'(dl_data);
		end
	end

	// a write pulse always carries a target bank
	assert property (@(posedge clk_sys) disable iff (!rst_n) wr_en |-> (wr_region != rgn_none));

endmodule

// ==== logic/cart_rom_banks.sv ====
// ################################################
// ten on-chip ROM banks, synchronous read
// data and selects line up one cycle after the address
// ROM3 is served from the rom7 bank
// ################################################

module cart_rom_banks
(
	input  logic                       clk_sys,
	input  logic                       rst_n,
	input  logic                       wr_en,
	input  sys1_cart_pkg::rom_region_e wr_region,
	input  sys1_cart_pkg::prog_addr_t  wr_word_addr,
	input  sys1_cart_pkg::snd_addr_t   wr_snd_addr,
	input  sys1_cart_pkg::prog_word_t  wr_word,
	input  sys1_cart_pkg::byte_t       wr_byte,
	input  sys1_cart_pkg::rom_sel_t    rom_sel,
	input  logic                       ma18_n,
	input  sys1_cart_pkg::prog_addr_t  prog_addr,
	input  sys1_cart_pkg::snd_sel_t    snd_sel,
	input  sys1_cart_pkg::snd_addr_t   snd_addr,
	output sys1_cart_pkg::prog_word_t  prog_data,
	output sys1_cart_pkg::byte_t       snd_data
);

	import sys1_cart_pkg::*;

	// ################################################
	// storage
	prog_word_t mem_rom0  [depth_short_words];
	prog_word_t mem_slap  [depth_short_words];
	prog_word_t mem_rom1  [depth_long_words];
	prog_word_t mem_rom2  [depth_long_words];
	prog_word_t mem_rom5  [depth_long_words];
	prog_word_t mem_rom6  [depth_long_words];
	prog_word_t mem_rom7  [depth_long_words];
	byte_t      mem_srom0 [depth_sound];
	byte_t      mem_srom1 [depth_sound];
	byte_t      mem_srom2 [depth_sound];

	// read data registers
	prog_word_t q_rom0, q_rom1, q_rom2, q_rom5, q_rom6, q_rom7, q_slap;
	byte_t      q_srom0, q_srom1, q_srom2;

	// selects sampled with the address
	rom_sel_t   rom_sel_q;
	logic       ma18_n_q;
	snd_sel_t   snd_sel_q;

	// writes by region, reads every cycle
	always_ff @(posedge clk_sys)
	begin
		if (wr_en)
		begin
			case (wr_region)
				rgn_rom0:  mem_rom0[wr_word_addr[13:0]] <= wr_word;
				rgn_slap:  mem_slap[wr_word_addr[13:0]] <= wr_word;
				rgn_rom1:  mem_rom1[wr_word_addr] <= wr_word;
				rgn_rom2:  mem_rom2[wr_word_addr] <= wr_word;
				rgn_rom5:  mem_rom5[wr_word_addr] <= wr_word;
				rgn_rom6:  mem_rom6[wr_word_addr] <= wr_word;
				rgn_rom7:  mem_rom7[wr_word_addr] <= wr_word;
				rgn_srom0: mem_srom0[wr_snd_addr] <= wr_byte;
				rgn_srom1: mem_srom1[wr_snd_addr] <= wr_byte;
				rgn_srom2: mem_srom2[wr_snd_addr] <= wr_byte;
				default: ;
			endcase
		end
		// 16K banks take the low 14 word bits
		q_rom0  <= mem_rom0[prog_addr[13:0]];
		q_slap  <= mem_slap[prog_addr[13:0]];
		q_rom1  <= mem_rom1[prog_addr];
		q_rom2  <= mem_rom2[prog_addr];
		q_rom5  <= mem_rom5[prog_addr];
		q_rom6  <= mem_rom6[prog_addr];
		q_rom7  <= mem_rom7[prog_addr];
		q_srom0 <= mem_srom0[snd_addr];
		q_srom1 <= mem_srom1[snd_addr];
		q_srom2 <= mem_srom2[snd_addr];
	end

	// idle selects give zero data out of reset
	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rom_sel_q <= '1;
			ma18_n_q  <= 1'b1;
			snd_sel_q <= '1;
		end
		else
		begin
			rom_sel_q <= rom_sel;
			ma18_n_q  <= ma18_n;
			snd_sel_q <= snd_sel;
		end
	end

	// ################################################
	// program mux, first match wins
	always_comb
	begin
		if (!rom_sel_q[0] && ma18_n_q)
			prog_data = q_rom0;
		else if (!rom_sel_q[1] && ma18_n_q)
			prog_data = q_rom1;
		else if (!rom_sel_q[2] && ma18_n_q)
			prog_data = q_rom2;
		else if (!rom_sel_q[3] && ma18_n_q)
			prog_data = q_rom7;
		else if (!rom_sel_q[1] && !ma18_n_q)
			prog_data = q_rom5;
		else if (!rom_sel_q[2] && !ma18_n_q)
			prog_data = q_rom6;
		// ROM3 alias
		else if (!rom_sel_q[3] && !ma18_n_q)
			prog_data = q_rom7;
		else if (!rom_sel_q[4])
			prog_data = q_slap;
		else
			prog_data = '0;
	end

	// sound mux
	always_comb
	begin
		if (!snd_sel_q[0])
			snd_data = q_srom0;
		else if (!snd_sel_q[1])
			snd_data = q_srom1;
		else if (!snd_sel_q[2])
			snd_data = q_srom2;
		else
			snd_data = '0;
	end

	// the sound CPU drives one ROM at a time
	assert property (@(posedge clk_sys) disable iff (!rst_n) $countones(~snd_sel) <= 1);

endmodule

// ==== logic/player_input_map.sv ====
// ################################################
// per game mapping of player controls
// inputs are already combined and active high
// outputs registered, one cycle behind the inputs
// ################################################

module player_input_map
(
	input  logic                      clk_sys,
	input  logic                      rst_n,
	input  sys1_cart_pkg::game_type_e game_type,
	input  sys1_cart_pkg::udlr_t      joy,
	input  logic                      btn_a,
	input  logic                      btn_b,
	input  logic                      mouse_l,
	input  logic                      mouse_r,
	input  logic                      mouse_swap,
	output sys1_cart_pkg::sw_bits_t   switches,
	output sys1_cart_pkg::adc_t       adc_b7,
	output sys1_cart_pkg::adc_t       adc_b6
);

	import sys1_cart_pkg::*;

	adc_t     dir;
	logic     ml;
	logic     mr;
	sw_bits_t sw_next;
	adc_t     b7_next;
	adc_t     b6_next;

	// optional mouse button exchange
	assign ml = mouse_swap ? mouse_r : mouse_l;
	assign mr = mouse_swap ? mouse_l : mouse_r;

	// indy wants 000UDLR0
	assign dir = (game_type == gt_indytemp) ? {3'b000, joy, 1'b0} : {4'b0000, joy};

	// ################################################
	// mapping
	always_comb
	begin
		// ADC idle at mid rail
		sw_next = '1;
		b7_next = 8'hFF;
		b6_next = 8'h00;
		case (game_type)
			gt_marble:
				sw_next = {3'b111, ~(btn_a | ml), ~(btn_b | mr)};
			gt_indytemp:
			begin
				b7_next = dir;
				b6_next = dir;
				sw_next = {3'b111, ~btn_a, ~btn_b};
			end
			gt_peterpak:
			begin
				b7_next = dir;
				b6_next = dir;
				// jump on SW3, throw on SW1
				sw_next = {2'b11, ~btn_a, 1'b1, ~btn_b};
			end
			gt_roadrunn:
			begin
				sw_next = {3'b111, ~btn_a, ~btn_b};
				// vertical, three state on bit 7
				if (dir[2])
					{b7_next[7], b6_next[7]} = 2'b11;
				else if (dir[3])
					{b7_next[7], b6_next[7]} = 2'b00;
				else
					{b7_next[7], b6_next[7]} = 2'b10;
				// horizontal on bit 0
				if (dir[0])
					{b7_next[0], b6_next[0]} = 2'b00;
				else if (dir[1])
					{b7_next[0], b6_next[0]} = 2'b11;
				else
					{b7_next[0], b6_next[0]} = 2'b10;
			end
			gt_roadb109, gt_roadb110:
			begin
				// fire on SW2, throttle through ADC bit 3
				sw_next    = {3'b111, ~btn_a, 1'b1};
				b7_next[3] = 1'b0;
				b6_next[3] = btn_b;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			switches <= '1;
			adc_b7   <= 8'hFF;
			adc_b6   <= 8'h00;
		end
		else
		begin
			switches <= sw_next;
			adc_b7   <= b7_next;
			adc_b6   <= b6_next;
		end
	end

endmodule

// ==== logic/sys1_cart.sv ====
// ################################################
// cartridge and control side of the board wrapper
// a downloaded byte reads back 3 cycles after its strobe
// ################################################

module sys1_cart
(
	input  logic                     clk_sys,
	input  logic                     rst_n,
	// download stream
	input  logic                     dl_download,
	input  logic                     dl_wr,
	input  sys1_cart_pkg::byte_t     dl_index,
	input  sys1_cart_pkg::dl_addr_t  dl_addr,
	input  sys1_cart_pkg::byte_t     dl_data,
	// board read side
	input  sys1_cart_pkg::rom_sel_t   rom_sel,
	input  logic                      ma18_n,
	input  sys1_cart_pkg::prog_addr_t prog_addr,
	input  sys1_cart_pkg::snd_sel_t   snd_sel,
	input  sys1_cart_pkg::snd_addr_t  snd_addr,
	output sys1_cart_pkg::prog_word_t prog_data,
	output sys1_cart_pkg::byte_t      snd_data,
	// player controls
	input  sys1_cart_pkg::udlr_t     joy,
	input  logic                     btn_a,
	input  logic                     btn_b,
	input  logic                     mouse_l,
	input  logic                     mouse_r,
	input  logic                     mouse_swap,
	output sys1_cart_pkg::sw_bits_t  switches,
	output sys1_cart_pkg::adc_t      adc_b7,
	output sys1_cart_pkg::adc_t      adc_b6
);

	import sys1_cart_pkg::*;

	// loader to banks
	logic        wr_en;
	rom_region_e wr_region;
	prog_addr_t  wr_word_addr;
	snd_addr_t   wr_snd_addr;
	prog_word_t  wr_word;
	byte_t       wr_byte;
	// loader to input map
	game_type_e  game_type;

	cart_loader u_loader (.*);

	cart_rom_banks u_banks (.*);

	player_input_map u_input_map (.*);

endmodule

// ==== test/sys1_cart_tb.sv ====
// ################################################
// testbench for the cartridge and control side
// expected values come from a model of the stream
// only written addresses are read back
// joystick stimulus never holds opposing directions
// ################################################

module sys1_cart_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import sys1_cart_pkg::*;

	localparam int clk_period    = 4;
	localparam int words_per_rgn = 32;
	localparam int bytes_per_rgn = 32;
	localparam int map_vectors   = 16;
	// even and odd byte per word, plus stray and type bytes
	localparam int stream_bytes = 7 * words_per_rgn * 2 + 3 * bytes_per_rgn + 5 + 7;
	localparam int read_count   = 9 * words_per_rgn + 3 * bytes_per_rgn + 5 + 7 * map_vectors;
	localparam int timeout_ns   = 4 * (stream_bytes + read_count) * clk_period;

	// ################################################
	// program regions in load order
	localparam rom_region_e prog_rgn [7] = '{rgn_rom0, rgn_rom1, rgn_rom2, rgn_rom5,
		rgn_rom6, rgn_rom7, rgn_slap};
	localparam dl_addr_t prog_base [7] = '{base_rom0, base_rom1, base_rom2, base_rom5,
		base_rom6, base_rom7, base_slap};
	// select combination that reaches each region
	localparam rom_sel_t prog_sel [7] = '{5'b11110, 5'b11101, 5'b11011, 5'b11101,
		5'b11011, 5'b10111, 5'b01111};
	localparam logic prog_ma [7] = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1};
	localparam rom_region_e snd_rgn [3] = '{rgn_srom0, rgn_srom1, rgn_srom2};
	localparam dl_addr_t snd_base [3] = '{base_srom0, base_srom1, base_srom2};
	// last code is undefined
	localparam byte_t type_codes [7] = '{gt_marble, gt_indytemp, gt_peterpak, gt_roadrunn,
		gt_roadb109, gt_roadb110, 8'd42};

	logic       clk_sys;
	logic       rst_n;
	logic       dl_download;
	logic       dl_wr;
	byte_t      dl_index;
	dl_addr_t   dl_addr;
	byte_t      dl_data;
	rom_sel_t   rom_sel;
	logic       ma18_n;
	prog_addr_t prog_addr;
	snd_sel_t   snd_sel;
	snd_addr_t  snd_addr;
	prog_word_t prog_data;
	byte_t      snd_data;
	udlr_t      joy;
	logic       btn_a;
	logic       btn_b;
	logic       mouse_l;
	logic       mouse_r;
	logic       mouse_swap;
	sw_bits_t   switches;
	adc_t       adc_b7;
	adc_t       adc_b6;

	// model keyed by region in the upper half, address in the lower
	prog_word_t ref_prog [int];
	byte_t      ref_snd [int];
	int         prog_offs [7][words_per_rgn];
	int         snd_offs [3][bytes_per_rgn];
	int         n_checks;
	int         n_errors;
	int         test_checks;
	int         test_errors;

	sys1_cart DUT (.*);

	initial
	begin
		clk_sys = 1'b0;
		forever #(clk_period / 2) clk_sys = ~clk_sys;
	end

	// watchdog
	initial
	begin
		#(timeout_ns);
		$display("timeout: no result after %0d ns, the run is stopped", timeout_ns);
		$display("sim failed");
		$finish;
	end

	// ################################################
	// reference functions
	function automatic int model_key(rom_region_e r, int a);
		return (int'(r) << 16) + a;
	endfunction

	function automatic prog_word_t exp_prog(rom_sel_t sel, logic m, prog_addr_t a);
		rom_region_e r;
		int k;
		if (!sel[0] && m)
			r = rgn_rom0;
		else if (!sel[1] && m)
			r = rgn_rom1;
		else if (!sel[2] && m)
			r = rgn_rom2;
		else if (!sel[3] && m)
			r = rgn_rom7;
		else if (!sel[1] && !m)
			r = rgn_rom5;
		else if (!sel[2] && !m)
			r = rgn_rom6;
		// ROM3 lives in rom7
		else if (!sel[3] && !m)
			r = rgn_rom7;
		else if (!sel[4])
			r = rgn_slap;
		else
			r = rgn_none;
		// short banks see 14 address bits
		if (r == rgn_rom0 || r == rgn_slap)
			k = model_key(r, int'(a[13:0]));
		else
			k = model_key(r, int'(a));
		if (r == rgn_none || !ref_prog.exists(k))
			return '0;
		return ref_prog[k];
	endfunction

	function automatic byte_t exp_snd(snd_sel_t sel, snd_addr_t a);
		rom_region_e r;
		int k;
		if (!sel[0])
			r = rgn_srom0;
		else if (!sel[1])
			r = rgn_srom1;
		else if (!sel[2])
			r = rgn_srom2;
		else
			r = rgn_none;
		k = model_key(r, int'(a));
		if (r == rgn_none || !ref_snd.exists(k))
			return '0;
		return ref_snd[k];
	endfunction

	// packed as switches, adc_b7, adc_b6
	function automatic logic [20:0] exp_map(byte_t gt, udlr_t j, logic a, logic b,
		logic ml, logic mr, logic swap);
		adc_t     dir;
		logic     l;
		logic     r;
		sw_bits_t s;
		adc_t     b7;
		adc_t     b6;
		l = swap ? mr : ml;
		r = swap ? ml : mr;
		dir = (gt == gt_indytemp) ? {3'b000, j, 1'b0} : {4'b0000, j};
		s = '1;
		b7 = 8'hFF;
		b6 = 8'h00;
		case (gt)
			gt_marble:
				s = {3'b111, ~(a | l), ~(b | r)};
			gt_indytemp:
			begin
				b7 = dir;
				b6 = dir;
				s = {3'b111, ~a, ~b};
			end
			gt_peterpak:
			begin
				b7 = dir;
				b6 = dir;
				s = {2'b11, ~a, 1'b1, ~b};
			end
			gt_roadrunn:
			begin
				s = {3'b111, ~a, ~b};
				// centre already holds b7 one, b6 zero
				if (j[2])
				begin
					b7[7] = 1'b1;
					b6[7] = 1'b1;
				end
				else if (j[3])
				begin
					b7[7] = 1'b0;
					b6[7] = 1'b0;
				end
				if (j[0])
				begin
					b7[0] = 1'b0;
					b6[0] = 1'b0;
				end
				else if (j[1])
				begin
					b7[0] = 1'b1;
					b6[0] = 1'b1;
				end
			end
			gt_roadb109, gt_roadb110:
			begin
				s = {3'b111, ~a, 1'b1};
				b7[3] = 1'b0;
				b6[3] = b;
			end
			default: ;
		endcase
		return {s, b7, b6};
	endfunction

	function automatic logic rand_bit();
		return 1'($urandom_range(1, 0));
	endfunction

	// ################################################
	// compare tasks
	task automatic check_prog(string name, prog_word_t exp, prog_word_t act);
		n_checks++;
		if (act !== exp)
		begin
			n_errors++;
			$display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_snd(string name, byte_t exp, byte_t act);
		n_checks++;
		if (act !== exp)
		begin
			n_errors++;
			$display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_sw(string name, sw_bits_t exp, sw_bits_t act);
		n_checks++;
		if (act !== exp)
		begin
			n_errors++;
			$display("error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_adc(string name, adc_t exp, adc_t act);
		n_checks++;
		if (act !== exp)
		begin
			n_errors++;
			$display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic report_test(string name);
		$display("test %s: %0d checks, %0d errors", name, n_checks - test_checks,
			n_errors - test_errors);
		test_checks = n_checks;
		test_errors = n_errors;
	endtask

	// ################################################
	// stream and read drivers
	task automatic send_byte(logic dl, byte_t idx, dl_addr_t a, byte_t d);
		@(posedge clk_sys);
		dl_download <= dl;
		dl_wr       <= 1'b1;
		dl_index    <= idx;
		dl_addr     <= a;
		dl_data     <= d;
	endtask

	task automatic stream_idle();
		@(posedge clk_sys);
		dl_wr       <= 1'b0;
		dl_download <= 1'b0;
	endtask

	// one cycle from address to data, sampled mid cycle
	task automatic read_prog(rom_sel_t sel, logic m, prog_addr_t a);
		prog_word_t exp;
		exp = exp_prog(sel, m, a);
		@(posedge clk_sys);
		rom_sel   <= sel;
		ma18_n    <= m;
		prog_addr <= a;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_prog("prog_data", exp, prog_data);
	endtask

	task automatic read_snd(snd_sel_t sel, snd_addr_t a);
		byte_t exp;
		exp = exp_snd(sel, a);
		@(posedge clk_sys);
		snd_sel  <= sel;
		snd_addr <= a;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_snd("snd_data", exp, snd_data);
	endtask

	// ################################################
	// test sequences
	task automatic load_programs();
		int off;
		prog_word_t data;
		for (int i = 0; i < 7; i++)
		begin
			for (int w = 0; w < words_per_rgn; w++)
			begin
				if (prog_rgn[i] == rgn_rom0 || prog_rgn[i] == rgn_slap)
					off = $urandom_range(depth_short_words - 1, 0);
				else
					off = $urandom_range(depth_long_words - 1, 0);
				data = prog_word_t'($urandom());
				prog_offs[i][w] = off;
				// high byte on the even address
				send_byte(1'b1, dl_index_rom, prog_base[i] + dl_addr_t'(2 * off), data[15:8]);
				send_byte(1'b1, dl_index_rom, prog_base[i] + dl_addr_t'(2 * off + 1), data[7:0]);
				ref_prog[model_key(prog_rgn[i], off)] = data;
			end
		end
	endtask

	task automatic load_sound();
		int off;
		byte_t data;
		for (int s = 0; s < 3; s++)
		begin
			for (int w = 0; w < bytes_per_rgn; w++)
			begin
				off = $urandom_range(depth_sound - 1, 0);
				data = byte_t'($urandom());
				snd_offs[s][w] = off;
				send_byte(1'b1, dl_index_rom, snd_base[s] + dl_addr_t'(off), data);
				ref_snd[model_key(snd_rgn[s], off)] = data;
			end
		end
	endtask

	task automatic read_programs();
		prog_addr_t a;
		for (int i = 0; i < 7; i++)
		begin
			for (int w = 0; w < words_per_rgn; w++)
			begin
				a = prog_addr_t'(prog_offs[i][w]);
				// top bit is ignored by the short banks
				if (prog_rgn[i] == rgn_rom0 || prog_rgn[i] == rgn_slap)
					a[14] = rand_bit();
				read_prog(prog_sel[i], prog_ma[i], a);
			end
		end
		for (int w = 0; w < words_per_rgn; w++)
		begin
			// ROM3 alias and the idle bus
			read_prog(5'b10111, 1'b0, prog_addr_t'(prog_offs[5][w]));
			read_prog(5'b11111, rand_bit(), prog_addr_t'(prog_offs[1][w]));
		end
	endtask

	task automatic read_sound();
		for (int s = 0; s < 3; s++)
		begin
			for (int w = 0; w < bytes_per_rgn; w++)
				read_snd(snd_sel_t'(~(3'b001 << s)), snd_addr_t'(snd_offs[s][w]));
		end
		read_snd(3'b111, snd_addr_t'(snd_offs[0][0]));
	endtask

	// bytes the loader must drop
	task automatic send_stray_bytes();
		dl_addr_t a;
		a = base_rom1 + dl_addr_t'(2 * prog_offs[1][0]);
		send_byte(1'b0, dl_index_rom, a, 8'h5A);
		send_byte(1'b0, dl_index_rom, a + 25'd1, 8'hA5);
		send_byte(1'b1, 8'd5, base_srom0 + dl_addr_t'(snd_offs[0][0]), 8'h3C);
		a = base_rom2 + dl_addr_t'(2 * prog_offs[2][0]);
		send_byte(1'b1, 8'd200, a, 8'hC3);
		send_byte(1'b1, 8'd200, a + 25'd1, 8'h69);
		stream_idle();
		read_prog(5'b11101, 1'b1, prog_addr_t'(prog_offs[1][0]));
		read_snd(3'b110, snd_addr_t'(snd_offs[0][0]));
		read_prog(5'b11011, 1'b1, prog_addr_t'(prog_offs[2][0]));
	endtask

	task automatic map_controls();
		int v;
		int h;
		udlr_t j;
		logic ba;
		logic bb;
		logic ml;
		logic mr;
		logic ms;
		logic [20:0] exp;
		for (int t = 0; t < 7; t++)
		begin
			// type byte with download low still counts
			send_byte(1'b0, dl_index_type, dl_addr_t'(t), type_codes[t]);
			stream_idle();
			for (int n = 0; n < map_vectors; n++)
			begin
				v = $urandom_range(2, 0);
				h = $urandom_range(2, 0);
				j = {v == 1, v == 2, h == 1, h == 2};
				ba = rand_bit();
				bb = rand_bit();
				ml = rand_bit();
				mr = rand_bit();
				ms = rand_bit();
				exp = exp_map(type_codes[t], j, ba, bb, ml, mr, ms);
				@(posedge clk_sys);
				joy        <= j;
				btn_a      <= ba;
				btn_b      <= bb;
				mouse_l    <= ml;
				mouse_r    <= mr;
				mouse_swap <= ms;
				@(posedge clk_sys);
				@(negedge clk_sys);
				check_sw("switches", exp[20:16], switches);
				check_adc("adc_b7", exp[15:8], adc_b7);
				check_adc("adc_b6", exp[7:0], adc_b6);
			end
		end
	endtask

	// ################################################
	// main sequence
	initial
	begin
		logic [20:0] exp_idle;
		void'($urandom(34436));
		n_checks    = 0;
		n_errors    = 0;
		test_checks = 0;
		test_errors = 0;
		rst_n       <= 1'b0;
		dl_download <= 1'b0;
		dl_wr       <= 1'b0;
		dl_index    <= '0;
		dl_addr     <= '0;
		dl_data     <= '0;
		rom_sel     <= '1;
		ma18_n      <= 1'b1;
		prog_addr   <= '0;
		snd_sel     <= '1;
		snd_addr    <= '0;
		joy         <= '0;
		btn_a       <= 1'b0;
		btn_b       <= 1'b0;
		mouse_l     <= 1'b0;
		mouse_r     <= 1'b0;
		mouse_swap  <= 1'b0;
		repeat (8) @(posedge clk_sys);
		rst_n <= 1'b1;
		// outputs still hold their reset values here
		@(negedge clk_sys);
		check_sw("switches", 5'b11111, switches);
		check_adc("adc_b7", 8'hFF, adc_b7);
		check_adc("adc_b6", 8'h00, adc_b6);
		check_prog("prog_data", 16'h0000, prog_data);
		check_snd("snd_data", 8'h00, snd_data);
		// first mapped cycle uses the reset game type
		exp_idle = exp_map(gt_indytemp, 4'b0000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
		@(negedge clk_sys);
		check_sw("switches", exp_idle[20:16], switches);
		check_adc("adc_b7", exp_idle[15:8], adc_b7);
		check_adc("adc_b6", exp_idle[7:0], adc_b6);
		report_test("reset values");
		load_programs();
		load_sound();
		stream_idle();
		read_programs();
		report_test("program readback");
		read_sound();
		report_test("sound readback");
		send_stray_bytes();
		report_test("stream qualification");
		map_controls();
		report_test("control mapping");
		$display("total: %0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// ==== sys1_cart.f ====
logic/sys1_cart_pkg.sv
logic/cart_loader.sv
logic/cart_rom_banks.sv
logic/player_input_map.sv
logic/sys1_cart.sv
test/sys1_cart_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cartridge testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f sys1_cart.f --top-module sys1_cart_tb -o sys1_cart_sim

# the simulator status is not trusted, the log decides
./obj_dir/sys1_cart_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log; then
	exit 1
fi
if ! grep -q "sim passed" sim.log; then
	echo "no verdict in sim.log"
	exit 1
fi
exit 0
